//--- design/wr_req_consts.svh
`ifndef WR_REQ_CONSTS_SVH
`define WR_REQ_CONSTS_SVH

// ******************************
// Data path
// ******************************

`define WR_REQ_DATA_WIDTH 32
`define WR_REQ_PORTS 5

// ******************************
// Buffering and flow control
// ******************************

`define WR_REQ_IN_DEPTH_BITS 4
`define WR_REQ_OUT_DEPTH_BITS 5
`define WR_REQ_BURST_LEN 4
// Fill levels at which a FIFO counts as almost full.
`define WR_REQ_IN_AFULL 12
`define WR_REQ_OUT_AFULL 24
`define WR_REQ_IDLE_GAP 2

`endif

//--- design/wr_req_data_pkg.sv
`default_nettype none

`include "wr_req_consts.svh"

package wr_req_data_pkg;

  // One client request word.
  typedef logic [`WR_REQ_DATA_WIDTH-1:0] req_word_t;

  // Word with its single-cycle write strobe.
  typedef struct packed {
    logic      en;
    req_word_t data;
  } wr_req_t;

endpackage

`default_nettype wire

//--- design/wr_req_ctrl_pkg.sv
`default_nettype none

`include "wr_req_consts.svh"

package wr_req_ctrl_pkg;

  // One bit per client port.
  typedef logic [`WR_REQ_PORTS-1:0] port_mask_t;

  typedef logic [$clog2(`WR_REQ_PORTS)-1:0] port_idx_t;

  // Sized for the larger output FIFO, full count included.
  typedef logic [`WR_REQ_OUT_DEPTH_BITS:0] fill_t;

  typedef struct packed {
    logic empty;
    logic almost_full;
    logic burst_ready;
  } fifo_status_t;

  typedef enum logic [1:0] {
    IDLE,
    READ,
    GAP
  } seq_state_e;

endpackage

`default_nettype wire

//--- design/req_fifo.sv
`timescale 1ns/10ps
`default_nettype none

`include "wr_req_consts.svh"

module req_fifo #(
  parameter int depth_bits = `WR_REQ_IN_DEPTH_BITS,
  parameter int afull = `WR_REQ_IN_AFULL
) (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        we,
  input  wire wr_req_data_pkg::req_word_t din,
  input  wire                        re,
  output logic                       valid,
  output wr_req_data_pkg::req_word_t dout,
  output wr_req_ctrl_pkg::fill_t     count,
  output logic                       empty,
  output logic                       almost_full
);

  import wr_req_data_pkg::*;
  import wr_req_ctrl_pkg::*;

  localparam int depth = 2 ** depth_bits;

  req_word_t mem [depth];

  logic [depth_bits-1:0] wr_ptr;
  logic [depth_bits-1:0] rd_ptr;
  logic wr_ok;
  logic rd_ok;

  // Writes to a full FIFO and reads of an empty one are dropped.
  assign wr_ok = we && (count != fill_t'(depth));
  assign rd_ok = re && !empty;

  assign empty = (count == '0);
  assign almost_full = (count >= fill_t'(afull));

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= din;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_ok) begin
      dout <= mem[rd_ptr];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      valid <= 1'b0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      valid <= rd_ok;
      case ({wr_ok, rd_ok})
        2'b10: count <= count + fill_t'(1);
        2'b01: count <= count - fill_t'(1);
        default: begin
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/req_input_bank.sv
`timescale 1ns/10ps
`default_nettype none

`include "wr_req_consts.svh"

module req_input_bank (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire wr_req_data_pkg::wr_req_t req_in [`WR_REQ_PORTS],
  output wr_req_ctrl_pkg::port_mask_t req_avail_in,
  input  wire wr_req_ctrl_pkg::port_mask_t rd_mask,
  output wr_req_ctrl_pkg::port_mask_t burst_ready,
  output wr_req_data_pkg::wr_req_t    sel_word
);

  import wr_req_data_pkg::*;
  import wr_req_ctrl_pkg::*;

  port_mask_t in_we;
  req_word_t in_din [`WR_REQ_PORTS];
  port_mask_t rd_valid;
  req_word_t rd_dout [`WR_REQ_PORTS];
  fill_t fill [`WR_REQ_PORTS];
  port_mask_t fifo_empty;
  port_mask_t fifo_afull;
  fifo_status_t status [`WR_REQ_PORTS];
  port_idx_t valid_idx;

  // Client strobes are registered before they reach the FIFOs.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_we <= '0;
      req_avail_in <= '0;
    end else begin
      for (int i = 0; i < `WR_REQ_PORTS; i++) begin
        in_we[i] <= req_in[i].en;
        req_avail_in[i] <= !status[i].almost_full;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `WR_REQ_PORTS; i++) begin
      in_din[i] <= req_in[i].data;
    end
  end

  for (genvar i = 0; i < `WR_REQ_PORTS; i++) begin : gen_fifo
    req_fifo #(
      .depth_bits(`WR_REQ_IN_DEPTH_BITS),
      .afull(`WR_REQ_IN_AFULL)
    ) u_fifo (
      .clk(clk),
      .rst_n(rst_n),
      .we(in_we[i]),
      .din(in_din[i]),
      .re(rd_mask[i]),
      .valid(rd_valid[i]),
      .dout(rd_dout[i]),
      .count(fill[i]),
      .empty(fifo_empty[i]),
      .almost_full(fifo_afull[i])
    );

    assign status[i] = '{
      empty: fifo_empty[i],
      almost_full: fifo_afull[i],
      burst_ready: (fill[i] >= fill_t'(`WR_REQ_BURST_LEN))
    };
    assign burst_ready[i] = status[i].burst_ready;
  end

  // Only one FIFO is read at a time.
  always_comb begin
    valid_idx = '0;
    for (int i = 0; i < `WR_REQ_PORTS; i++) begin
      if (rd_valid[i]) begin
        valid_idx = port_idx_t'(i);
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sel_word.en <= 1'b0;
    end else begin
      sel_word.en <= |rd_valid;
      sel_word.data <= rd_dout[valid_idx];
    end
  end

endmodule

`default_nettype wire

//--- design/rr_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

`include "wr_req_consts.svh"

module rr_arbiter (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire wr_req_ctrl_pkg::port_mask_t request,
  input  wire                         advance,
  output wr_req_ctrl_pkg::port_mask_t grant,
  output logic                        grant_valid
);

  import wr_req_ctrl_pkg::*;

  localparam port_idx_t last_port = port_idx_t'(`WR_REQ_PORTS - 1);

  // First port searched in the current round.
  port_idx_t ptr;
  port_idx_t grant_idx;

  always_comb begin
    int idx;
    grant = '0;
    grant_valid = 1'b0;
    grant_idx = '0;
    for (int i = 0; i < `WR_REQ_PORTS; i++) begin
      idx = int'(ptr) + i;
      if (idx >= `WR_REQ_PORTS) begin
        idx = idx - `WR_REQ_PORTS;
      end
      if (!grant_valid && request[idx]) begin
        grant[idx] = 1'b1;
        grant_valid = 1'b1;
        grant_idx = port_idx_t'(idx);
      end
    end
  end

  // The served port drops to lowest priority.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (advance) begin
      if (grant_idx == last_port) begin
        ptr <= '0;
      end else begin
        ptr <= grant_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/burst_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "wr_req_consts.svh"

module burst_sequencer (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire wr_req_ctrl_pkg::port_mask_t grant,
  input  wire                         grant_valid,
  output logic                        advance,
  output wr_req_ctrl_pkg::port_mask_t rd_mask
);

  import wr_req_ctrl_pkg::*;

  localparam int burst_w = $clog2(`WR_REQ_BURST_LEN + 1);
  localparam int gap_w = $clog2(`WR_REQ_IDLE_GAP + 1);

  localparam logic [burst_w-1:0] burst_last = burst_w'(`WR_REQ_BURST_LEN - 1);
  localparam logic [gap_w-1:0] gap_last = gap_w'(`WR_REQ_IDLE_GAP - 1);

  seq_state_e state;
  logic [burst_w-1:0] burst_cnt;
  logic [gap_w-1:0] gap_cnt;

  // Accepting a grant moves the arbiter pointer in the same edge.
  assign advance = (state == IDLE) && grant_valid;

  // ******************************
  // Burst FSM
  // ******************************

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      rd_mask <= '0;
      burst_cnt <= '0;
      gap_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (grant_valid) begin
            rd_mask <= grant;
            burst_cnt <= '0;
            state <= READ;
          end
        end
        READ: begin
          // One read strobe per cycle to the latched port.
          if (burst_cnt == burst_last) begin
            rd_mask <= '0;
            gap_cnt <= '0;
            state <= GAP;
          end else begin
            burst_cnt <= burst_cnt + 1'b1;
          end
        end
        GAP: begin
          // Lets the fill levels settle before the next grant.
          if (gap_cnt == gap_last) begin
            state <= IDLE;
          end else begin
            gap_cnt <= gap_cnt + 1'b1;
          end
        end
        default: begin
          rd_mask <= '0;
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/wr_req_merge_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "wr_req_consts.svh"

module wr_req_merge_top (
  input  wire                         clk,
  input  wire                         rst_n,
  input  wire wr_req_data_pkg::wr_req_t req_in [`WR_REQ_PORTS],
  output wr_req_ctrl_pkg::port_mask_t req_avail_in,
  input  wire                         avail_out,
  output wr_req_data_pkg::wr_req_t    req_out
);

  import wr_req_data_pkg::*;
  import wr_req_ctrl_pkg::*;

  port_mask_t burst_ready;
  port_mask_t arb_request;
  port_mask_t grant;
  port_mask_t rd_mask;
  logic grant_valid;
  logic advance;
  wr_req_t sel_word;

  logic out_re;
  logic out_valid;
  req_word_t out_dout;
  logic out_empty;
  logic out_afull;

  // ******************************
  // Input side
  // ******************************

  req_input_bank u_bank (
    .clk(clk),
    .rst_n(rst_n),
    .req_in(req_in),
    .req_avail_in(req_avail_in),
    .rd_mask(rd_mask),
    .burst_ready(burst_ready),
    .sel_word(sel_word)
  );

  // No new burst starts once the output FIFO is almost full.
  assign arb_request = burst_ready & {`WR_REQ_PORTS{!out_afull}};

  rr_arbiter u_arbiter (
    .clk(clk),
    .rst_n(rst_n),
    .request(arb_request),
    .advance(advance),
    .grant(grant),
    .grant_valid(grant_valid)
  );

  burst_sequencer u_sequencer (
    .clk(clk),
    .rst_n(rst_n),
    .grant(grant),
    .grant_valid(grant_valid),
    .advance(advance),
    .rd_mask(rd_mask)
  );

  // ******************************
  // Output side
  // ******************************

  assign out_re = avail_out && !out_empty;

  req_fifo #(
    .depth_bits(`WR_REQ_OUT_DEPTH_BITS),
    .afull(`WR_REQ_OUT_AFULL)
  ) u_out_fifo (
    .clk(clk),
    .rst_n(rst_n),
    .we(sel_word.en),
    .din(sel_word.data),
    .re(out_re),
    .valid(out_valid),
    .dout(out_dout),
    .count(),
    .empty(out_empty),
    .almost_full(out_afull)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_out.en <= 1'b0;
    end else begin
      req_out.en <= out_valid;
      req_out.data <= out_dout;
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_wr_req_merge_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "wr_req_consts.svh"

module tb_wr_req_merge_top;

  import wr_req_data_pkg::*;
  import wr_req_ctrl_pkg::*;

  localparam int max_words = 64;
  localparam int max_lines = 64;
  localparam int burst = `WR_REQ_BURST_LEN;

  logic clk;
  logic rst_n;
  wr_req_t req_in [`WR_REQ_PORTS];
  port_mask_t req_avail_in;
  logic avail_out;
  wr_req_t req_out;

  logic [15:0] testdata [4*max_lines];
  int num_lines;
  logic data_loaded;
  integer seed;
  int cyc;

  // ******************************
  // Scoreboard state
  // ******************************

  req_word_t exp_word [`WR_REQ_PORTS][max_words];
  int push_cyc [`WR_REQ_PORTS][max_words];
  int push_cnt [`WR_REQ_PORTS];
  int pop_cnt [`WR_REQ_PORTS];
  int bursts [`WR_REQ_PORTS];
  // Push cycle of the last word in the previous burst of each port.
  int prev_push [`WR_REQ_PORTS];
  logic [`WR_REQ_PORTS-1:0] served_since [`WR_REQ_PORTS];
  int group_port;
  int group_cnt;
  int rx_total;
  int blocked;

  wr_req_merge_top u_dut (
    .clk(clk),
    .rst_n(rst_n),
    .req_in(req_in),
    .req_avail_in(req_avail_in),
    .avail_out(avail_out),
    .req_out(req_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  task automatic stop_with_failure();
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
      stop_with_failure();
    end
  endtask

  // A port that held a full burst when p was last granted must come before p again.
  task automatic check_round_robin(input int p);
    int idx;
    for (int q = 0; q < `WR_REQ_PORTS; q++) begin
      idx = burst * bursts[q] + burst - 1;
      if (q != p && prev_push[p] >= 0 && !served_since[p][q] && idx < push_cnt[q]) begin
        if (push_cyc[q][idx] <= prev_push[p]) begin
          $display("Port %0d was served twice while port %0d waited with a full burst", p, q);
          stop_with_failure();
        end
      end
    end
  endtask

  task automatic check_output_word();
    int p;
    if (req_out.en) begin
      p = int'(req_out.data[31:24]);
      if (p >= `WR_REQ_PORTS || pop_cnt[p] >= push_cnt[p]) begin
        $display("Output word %0h was never pushed by any client", req_out.data);
        stop_with_failure();
      end
      compare_values(req_out.data, exp_word[p][pop_cnt[p]], "word order of a port");
      if (group_cnt == 0) begin
        group_port = p;
      end
      compare_values(p, group_port, "port within a burst");
      pop_cnt[p]++;
      group_cnt++;
      rx_total++;
      if (group_cnt == burst) begin
        check_round_robin(p);
        prev_push[p] = push_cyc[p][burst * bursts[p] + burst - 1];
        served_since[p] = '0;
        for (int q = 0; q < `WR_REQ_PORTS; q++) begin
          served_since[q][p] = 1'b1;
        end
        bursts[p]++;
        group_cnt = 0;
      end
    end
  endtask

  task automatic drive_inputs(input logic [15:0] mask, input logic [15:0] base,
                              input logic avail);
    for (int i = 0; i < `WR_REQ_PORTS; i++) begin
      req_in[i] = '0;
      if (mask[i] && req_avail_in[i]) begin
        req_in[i].en = 1'b1;
        req_in[i].data = {8'(i), base[7:0], 16'(push_cnt[i])};
        exp_word[i][push_cnt[i]] = req_in[i].data;
        push_cyc[i][push_cnt[i]] = cyc;
        push_cnt[i]++;
      end else if (mask[i]) begin
        blocked++;
      end
    end
    avail_out = avail;
  endtask

  // Outputs are sampled before the new inputs go out on the same falling edge.
  task automatic run_cycle(input logic [15:0] mask, input logic [15:0] base,
                           input logic avail);
    @(negedge clk);
    cyc++;
    check_output_word();
    drive_inputs(mask, base, avail);
  endtask

  initial begin
    wait (data_loaded);
    repeat (num_lines * 50) @(posedge clk);
    $display("Timeout: the DUT did not deliver the expected words in time");
    stop_with_failure();
  end

  initial begin
    int idle;
    int exp_total;
    logic last_avail;
    rst_n = 1'b0;
    avail_out = 1'b0;
    data_loaded = 1'b0;
    seed = 78;
    cyc = 0;
    group_port = 0;
    group_cnt = 0;
    rx_total = 0;
    blocked = 0;
    for (int p = 0; p < `WR_REQ_PORTS; p++) begin
      req_in[p] = '0;
      push_cnt[p] = 0;
      pop_cnt[p] = 0;
      bursts[p] = 0;
      prev_push[p] = -1;
      served_since[p] = '0;
    end
    $readmemh("testbench/wr_req_merge_testdata.txt", testdata);
    num_lines = 0;
    while (num_lines < max_lines && testdata[4*num_lines] !== 16'h00ff) begin
      num_lines++;
    end
    if (num_lines == max_lines) begin
      $display("The test data file has no expected-total line");
      stop_with_failure();
    end
    data_loaded = 1'b1;

    // ******************************
    // Reset
    // ******************************
    repeat (2) @(posedge clk);
    @(negedge clk);
    compare_values(req_avail_in, 32'h0, "availability during reset");
    compare_values(req_out.en, 32'h0, "output strobe during reset");
    rst_n = 1'b1;
    run_cycle(16'h0, 16'h0, 1'b0);
    compare_values(req_avail_in, 32'h1f, "availability after reset");

    // ******************************
    // File-driven stimulus
    // ******************************
    for (int line = 0; line < num_lines; line++) begin
      repeat (testdata[4*line + 2]) begin
        run_cycle(testdata[4*line], testdata[4*line + 1], testdata[4*line + 3][0]);
      end
      last_avail = testdata[4*line + 3][0];
      idle = $unsigned($random(seed)) % 4;
      repeat (idle) begin
        run_cycle(16'h0, 16'h0, last_avail);
      end
    end

    exp_total = 0;
    for (int p = 0; p < `WR_REQ_PORTS; p++) begin
      exp_total += (push_cnt[p] / burst) * burst;
    end
    compare_values(exp_total, testdata[4*num_lines + 1], "total against the data file");
    while (rx_total < exp_total) begin
      run_cycle(16'h0, 16'h0, 1'b1);
    end
    // Leftover partial bursts must stay inside their FIFOs.
    repeat (30) begin
      run_cycle(16'h0, 16'h0, 1'b1);
    end
    compare_values(rx_total, exp_total, "number of output words");
    compare_values(blocked > 0, 1, "availability drop of a full input FIFO");
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- wr_req_merge_top.f
+incdir+design
design/wr_req_data_pkg.sv
design/wr_req_ctrl_pkg.sv
design/req_fifo.sv
design/req_input_bank.sv
design/rr_arbiter.sv
design/burst_sequencer.sv
design/wr_req_merge_top.sv
testbench/tb_wr_req_merge_top.sv

//--- testbench/wr_req_merge_testdata.txt
// Columns (hex): client port mask, base data byte, cycles to hold the line, avail_out.
// The last line has mask ff and gives the expected number of output words.
01 a0 04 1
00 00 0c 1
1f a1 08 1
00 00 50 1
06 b2 06 1
18 b3 03 1
00 00 20 1
0f c4 08 0
00 00 40 0
10 c5 18 0
00 00 10 0
00 00 30 1
11 d6 08 1
0e d7 05 0
0f d8 03 1
00 00 06 0
04 d9 01 1
00 00 08 1
ff 88 00 0
